//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - src/mem_types_pkg.sv
  - src/mem_arbiter.sv
  - src/instr_line_buffer.sv
  - src/data_line_buffer.sv
  - src/pmem_model.sv
  - src/mem_subsystem.sv
  - target: test
    files:
      - tests/mem_subsystem_tb.sv

//--- build.f
src/mem_types_pkg.sv
src/mem_arbiter.sv
src/instr_line_buffer.sv
src/data_line_buffer.sv
src/pmem_model.sv
src/mem_subsystem.sv
tests/mem_subsystem_tb.sv

//--- src/data_line_buffer.sv
module data_line_buffer (
    input  logic                 clk,
    input  logic                 rst,

    // CPU load/store side
    input  mem_types_pkg::addr_t data_addr,
    input  logic                 data_read,
    input  logic                 data_write,
    input  mem_types_pkg::word_t data_wdata,
    output mem_types_pkg::word_t data_rdata,
    output logic                 data_resp,

    // Toward the arbiter
    output mem_types_pkg::addr_t data_mem_addr,
    output logic                 data_mem_read,
    output logic                 data_mem_write,
    output mem_types_pkg::line_t data_mem_wline,
    input  mem_types_pkg::line_t data_mem_rline,
    input  logic                 data_mem_resp
);

    localparam int TAG_LSB = $bits(mem_types_pkg::addr_t) - $bits(mem_types_pkg::tag_t);
    localparam int WORD_W = $bits(mem_types_pkg::word_t);

    enum logic [1:0] {
        IDLE,
        WRITE_BACK,
        FILL,
        RESPOND
    } state_q;

    // Held line with its state bits
    mem_types_pkg::line_t line_q;
    mem_types_pkg::tag_t  tag_q;
    logic                 valid_q;
    logic                 dirty_q;
    // Answered, wait for both levels to drop
    logic                 served_q;

    mem_types_pkg::tag_t    req_tag;
    mem_types_pkg::offset_t req_off;
    mem_types_pkg::line_t   fill_line;
    logic                   req_level;
    logic                   new_req;
    logic                   hit;

    assign req_tag   = data_addr[TAG_LSB +: $bits(mem_types_pkg::tag_t)];
    assign req_off   = data_addr[mem_types_pkg::OFFSET_LSB +: $bits(mem_types_pkg::offset_t)];
    assign req_level = data_read || data_write;
    assign new_req   = req_level && !served_q;
    assign hit       = valid_q && (tag_q == req_tag);

    // Fetched line with the store word merged in on a write miss
    always_comb begin
        fill_line = data_mem_rline;
        if (data_write) begin
            fill_line[req_off * WORD_W +: WORD_W] = data_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= IDLE;
            valid_q  <= 1'b0;
            dirty_q  <= 1'b0;
            served_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!req_level) begin
                        served_q <= 1'b0;
                    end
                    if (new_req) begin
                        if (hit) begin
                            dirty_q <= dirty_q || data_write;
                            state_q <= RESPOND;
                        end else if (valid_q && dirty_q) begin
                            // Evict first
                            state_q <= WRITE_BACK;
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (data_mem_resp) begin
                        dirty_q <= 1'b0;
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (data_mem_resp) begin
                        valid_q <= 1'b1;
                        dirty_q <= data_write;
                        state_q <= RESPOND;
                    end
                end
                RESPOND: begin
                    served_q <= 1'b1;
                    state_q  <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Line contents
    always_ff @(posedge clk) begin
        if (state_q == IDLE && new_req && hit && data_write) begin
            line_q[req_off * WORD_W +: WORD_W] <= data_wdata;
        end else if (state_q == FILL && data_mem_resp) begin
            line_q <= fill_line;
            tag_q  <= req_tag;
        end
    end

    // Write-back goes to the old tag, fill to the requested one
    assign data_mem_addr  = (state_q == WRITE_BACK) ? {tag_q, {TAG_LSB{1'b0}}}
                                                    : {req_tag, {TAG_LSB{1'b0}}};
    assign data_mem_write = (state_q == WRITE_BACK);
    assign data_mem_read  = (state_q == FILL);
    assign data_mem_wline = line_q;

    // After a store this reads back the merged word
    assign data_rdata = line_q[req_off * WORD_W +: WORD_W];
    assign data_resp  = (state_q == RESPOND);

endmodule

//--- src/instr_line_buffer.sv
module instr_line_buffer (
    input  logic                 clk,
    input  logic                 rst,

    // CPU fetch side
    input  mem_types_pkg::addr_t instr_addr,
    input  logic                 instr_read,
    output mem_types_pkg::word_t instr_rdata,
    output logic                 instr_resp,

    // Toward the arbiter
    output mem_types_pkg::addr_t instr_mem_addr,
    output logic                 instr_mem_read,
    input  mem_types_pkg::line_t instr_mem_line,
    input  logic                 instr_mem_resp
);

    // Bits below the tag, zeroed in the line address
    localparam int TAG_LSB = $bits(mem_types_pkg::addr_t) - $bits(mem_types_pkg::tag_t);
    localparam int WORD_W = $bits(mem_types_pkg::word_t);

    // Held line
    mem_types_pkg::line_t line_q;
    mem_types_pkg::tag_t  tag_q;
    logic                 valid_q;

    // Miss outstanding at the arbiter
    logic fetching_q;
    logic resp_q;
    // Already answered, wait for the read level to drop
    logic served_q;

    mem_types_pkg::tag_t    req_tag;
    mem_types_pkg::offset_t req_off;
    logic                   hit;
    logic                   new_req;

    assign req_tag = instr_addr[TAG_LSB +: $bits(mem_types_pkg::tag_t)];
    assign req_off = instr_addr[mem_types_pkg::OFFSET_LSB +: $bits(mem_types_pkg::offset_t)];
    assign hit     = valid_q && (tag_q == req_tag);
    assign new_req = instr_read && !served_q && !fetching_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            fetching_q <= 1'b0;
            resp_q     <= 1'b0;
            served_q   <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            if (!instr_read) begin
                served_q <= 1'b0;
            end
            if (new_req && hit) begin
                // Hit answers on the next cycle
                resp_q   <= 1'b1;
                served_q <= 1'b1;
            end else if (new_req) begin
                fetching_q <= 1'b1;
            end
            if (fetching_q && instr_mem_resp) begin
                fetching_q <= 1'b0;
                valid_q    <= 1'b1;
                resp_q     <= 1'b1;
                served_q   <= 1'b1;
            end
        end
    end

    // Line fill
    always_ff @(posedge clk) begin
        if (fetching_q && instr_mem_resp) begin
            line_q <= instr_mem_line;
            tag_q  <= req_tag;
        end
    end

    // Line-aligned fetch address
    assign instr_mem_addr = {req_tag, {TAG_LSB{1'b0}}};
    assign instr_mem_read = fetching_q;

    // Address is held, so the word select stays valid through the pulse
    assign instr_rdata = line_q[req_off * WORD_W +: WORD_W];
    assign instr_resp  = resp_q;

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter (
    input  logic                 clk,
    input  logic                 rst,

    // Instruction buffer side, read only
    input  mem_types_pkg::addr_t instr_mem_addr,
    input  logic                 instr_mem_read,
    output mem_types_pkg::line_t instr_mem_line,
    output logic                 instr_mem_resp,

    // Data buffer side
    input  mem_types_pkg::addr_t data_mem_addr,
    input  logic                 data_mem_read,
    input  logic                 data_mem_write,
    input  mem_types_pkg::line_t data_mem_wline,
    output mem_types_pkg::line_t data_mem_rline,
    output logic                 data_mem_resp,

    // Shared memory port
    output mem_types_pkg::addr_t mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output mem_types_pkg::line_t mem_wline,
    input  mem_types_pkg::line_t mem_rline,
    input  logic                 mem_resp
);

    // Grant FSM
    enum logic [1:0] {
        IDLE,
        INSTR,
        DATA,
        DONE
    } state_q;

    // Owner of the current grant, 1 means data side
    logic owner_data_q;
    // Side served by the last finished transaction
    logic last_data_q;
    // Line captured on mem_resp, forwarded in DONE
    mem_types_pkg::line_t rline_q;

    logic instr_req;
    logic data_req;
    logic pick_data;

    assign instr_req = instr_mem_read;
    assign data_req  = data_mem_read || data_mem_write;

    // Data wins when alone, or on a tie if instr was served last
    assign pick_data = data_req && (!instr_req || !last_data_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= IDLE;
            owner_data_q <= 1'b0;
            // Instr side wins the first tie after reset
            last_data_q  <= 1'b1;
        end else begin
            case (state_q)
                IDLE: begin
                    if (instr_req || data_req) begin
                        state_q      <= pick_data ? DATA : INSTR;
                        owner_data_q <= pick_data;
                    end
                end
                INSTR, DATA: begin
                    if (mem_resp) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    // Requester drops its level during this cycle
                    state_q     <= IDLE;
                    last_data_q <= owner_data_q;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Returned line
    always_ff @(posedge clk) begin
        if ((state_q == INSTR || state_q == DATA) && mem_resp) begin
            rline_q <= mem_rline;
        end
    end

    // Memory port mux, only driven while granted
    always_comb begin
        mem_addr       = '0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_wline      = '0;
        instr_mem_resp = 1'b0;
        data_mem_resp  = 1'b0;
        case (state_q)
            INSTR: begin
                mem_addr = instr_mem_addr;
                mem_read = instr_mem_read;
            end
            DATA: begin
                mem_addr  = data_mem_addr;
                mem_read  = data_mem_read;
                mem_write = data_mem_write;
                mem_wline = data_mem_wline;
            end
            DONE: begin
                // One-cycle pulse to whoever held the grant
                instr_mem_resp = !owner_data_q;
                data_mem_resp  = owner_data_q;
            end
            default: ;
        endcase
    end

    // Both sides see the captured line, only the owner gets a pulse
    assign instr_mem_line = rline_q;
    assign data_mem_rline = rline_q;

endmodule

//--- src/mem_subsystem.sv
module mem_subsystem #(
    parameter int PMEM_LINES   = 16,
    parameter int PMEM_LATENCY = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    // Instruction fetch port
    input  mem_types_pkg::addr_t instr_addr,
    input  logic                 instr_read,
    output mem_types_pkg::word_t instr_rdata,
    output logic                 instr_resp,

    // Data load/store port
    input  mem_types_pkg::addr_t data_addr,
    input  logic                 data_read,
    input  logic                 data_write,
    input  mem_types_pkg::word_t data_wdata,
    output mem_types_pkg::word_t data_rdata,
    output logic                 data_resp
);

    // Instr buffer to arbiter
    mem_types_pkg::addr_t instr_mem_addr;
    logic                 instr_mem_read;
    mem_types_pkg::line_t instr_mem_line;
    logic                 instr_mem_resp;

    // Data buffer to arbiter
    mem_types_pkg::addr_t data_mem_addr;
    logic                 data_mem_read;
    logic                 data_mem_write;
    mem_types_pkg::line_t data_mem_wline;
    mem_types_pkg::line_t data_mem_rline;
    logic                 data_mem_resp;

    // Arbiter to memory
    mem_types_pkg::addr_t mem_addr;
    logic                 mem_read;
    logic                 mem_write;
    mem_types_pkg::line_t mem_wline;
    mem_types_pkg::line_t mem_rline;
    logic                 mem_resp;

    instr_line_buffer instr_line_buffer_i (
        .clk            (clk),
        .rst            (rst),
        .instr_addr     (instr_addr),
        .instr_read     (instr_read),
        .instr_rdata    (instr_rdata),
        .instr_resp     (instr_resp),
        .instr_mem_addr (instr_mem_addr),
        .instr_mem_read (instr_mem_read),
        .instr_mem_line (instr_mem_line),
        .instr_mem_resp (instr_mem_resp)
    );

    data_line_buffer data_line_buffer_i (
        .clk            (clk),
        .rst            (rst),
        .data_addr      (data_addr),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_wdata     (data_wdata),
        .data_rdata     (data_rdata),
        .data_resp      (data_resp),
        .data_mem_addr  (data_mem_addr),
        .data_mem_read  (data_mem_read),
        .data_mem_write (data_mem_write),
        .data_mem_wline (data_mem_wline),
        .data_mem_rline (data_mem_rline),
        .data_mem_resp  (data_mem_resp)
    );

    mem_arbiter mem_arbiter_i (
        .clk            (clk),
        .rst            (rst),
        .instr_mem_addr (instr_mem_addr),
        .instr_mem_read (instr_mem_read),
        .instr_mem_line (instr_mem_line),
        .instr_mem_resp (instr_mem_resp),
        .data_mem_addr  (data_mem_addr),
        .data_mem_read  (data_mem_read),
        .data_mem_write (data_mem_write),
        .data_mem_wline (data_mem_wline),
        .data_mem_rline (data_mem_rline),
        .data_mem_resp  (data_mem_resp),
        .mem_addr       (mem_addr),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_wline      (mem_wline),
        .mem_rline      (mem_rline),
        .mem_resp       (mem_resp)
    );

    pmem_model #(
        .PMEM_LINES   (PMEM_LINES),
        .PMEM_LATENCY (PMEM_LATENCY)
    ) pmem_model_i (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wline (mem_wline),
        .mem_rline (mem_rline),
        .mem_resp  (mem_resp)
    );

endmodule

//--- src/mem_types_pkg.sv
package mem_types_pkg;

    // Line geometry
    // Eight words per line, word index starts above the byte offset
    localparam int WORDS_PER_LINE = 8;
    localparam int OFFSET_LSB = 2;

    // One CPU word, data or instruction
    typedef logic [31:0] word_t;

    // Byte address
    typedef logic [31:0] addr_t;

    // Full memory line, words packed low word first
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    // Word index inside a line
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] offset_t;

    // Line address, i.e. byte address minus the line offset bits
    typedef logic [31-OFFSET_LSB-$clog2(WORDS_PER_LINE):0] tag_t;

endpackage

//--- src/pmem_model.sv
module pmem_model #(
    parameter int PMEM_LINES   = 16,
    parameter int PMEM_LATENCY = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mem_types_pkg::addr_t mem_addr,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  mem_types_pkg::line_t mem_wline,
    output mem_types_pkg::line_t mem_rline,
    output logic                 mem_resp
);

    localparam int TAG_LSB = $bits(mem_types_pkg::addr_t) - $bits(mem_types_pkg::tag_t);
    localparam int IDX_W = $clog2(PMEM_LINES);
    localparam int CNT_W = $clog2(PMEM_LATENCY + 1);

    // Line index, upper address bits wrap around
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    mem_types_pkg::line_t mem_q [PMEM_LINES];

    logic                 busy_q;
    cnt_t                 count_q;
    // Request captured when first seen
    idx_t                 idx_q;
    logic                 write_q;
    mem_types_pkg::line_t wline_q;

    idx_t req_idx;
    logic start;
    logic expire;

    assign req_idx = mem_addr[TAG_LSB +: IDX_W];
    assign start   = !busy_q && (mem_read || mem_write);
    // Counter hits zero exactly PMEM_LATENCY cycles after start
    assign expire  = busy_q && (count_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            count_q <= '0;
            for (int i = 0; i < PMEM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (start) begin
            busy_q  <= 1'b1;
            count_q <= cnt_t'(PMEM_LATENCY - 1);
        end else if (expire) begin
            busy_q <= 1'b0;
            // Store lands on the response cycle
            if (write_q) begin
                mem_q[idx_q] <= wline_q;
            end
        end else if (busy_q) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            idx_q   <= req_idx;
            write_q <= mem_write;
            wline_q <= mem_wline;
        end
    end

    assign mem_rline = mem_q[idx_q];
    assign mem_resp  = expire;

endmodule

//--- tests/mem_subsystem_tb.sv
module mem_subsystem_tb;

    localparam int PMEM_LINES   = 16;
    localparam int PMEM_LATENCY = 4;
    localparam int NUM_RANDOM   = 40;
    localparam int OFF_W        = $bits(mem_types_pkg::offset_t);
    localparam int LINE_SHIFT   = mem_types_pkg::OFFSET_LSB + OFF_W;
    localparam int LINE_BYTES   = 1 << LINE_SHIFT;

    // One table row with the instr side first
    typedef struct {
        logic                 i_en;
        mem_types_pkg::addr_t i_addr;
        logic                 d_en;
        logic                 d_wr;
        mem_types_pkg::addr_t d_addr;
        mem_types_pkg::word_t d_wdata;
    } row_t;

    logic                 clk;
    logic                 rst;
    mem_types_pkg::addr_t instr_addr;
    logic                 instr_read;
    mem_types_pkg::word_t instr_rdata;
    logic                 instr_resp;
    mem_types_pkg::addr_t data_addr;
    logic                 data_read;
    logic                 data_write;
    mem_types_pkg::word_t data_wdata;
    mem_types_pkg::word_t data_rdata;
    logic                 data_resp;

    row_t rows[$];
    int   errors;
    int   timeouts;
    int   cycle_count;
    int   cycle_limit;

    // Reference memory starts at zero like the DUT after reset
    mem_types_pkg::line_t ref_mem [PMEM_LINES];
    // Mirror of the instr buffer
    mem_types_pkg::line_t i_line;
    mem_types_pkg::tag_t  i_tag;
    logic                 i_valid;
    // Mirror of the data buffer
    mem_types_pkg::line_t d_line;
    mem_types_pkg::tag_t  d_tag;
    logic                 d_valid;
    logic                 d_dirty;
    // Side served by the last memory transaction
    logic                 last_data;

    mem_subsystem #(
        .PMEM_LINES   (PMEM_LINES),
        .PMEM_LATENCY (PMEM_LATENCY)
    ) mem_subsystem_i (
        .clk         (clk),
        .rst         (rst),
        .instr_addr  (instr_addr),
        .instr_read  (instr_read),
        .instr_rdata (instr_rdata),
        .instr_resp  (instr_resp),
        .data_addr   (data_addr),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .data_resp   (data_resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic mem_types_pkg::tag_t tag_of(mem_types_pkg::addr_t a);
        return mem_types_pkg::tag_t'(a >> LINE_SHIFT);
    endfunction

    // Memory wraps modulo its depth
    function automatic int index_of(mem_types_pkg::tag_t t);
        return int'(t % PMEM_LINES);
    endfunction

    function automatic int word_pos(mem_types_pkg::addr_t a);
        return int'(a[mem_types_pkg::OFFSET_LSB +: OFF_W]) * 32;
    endfunction

    function automatic mem_types_pkg::addr_t random_addr();
        int sel;
        int word;
        sel  = $urandom % 4;
        word = $urandom % mem_types_pkg::WORDS_PER_LINE;
        // Lines 0 and 1 plus their aliases one depth up
        return mem_types_pkg::addr_t'(((sel / 2) * PMEM_LINES + sel % 2) * LINE_BYTES + word * 4);
    endfunction

    task automatic add_row(input logic i_en, input mem_types_pkg::addr_t i_addr,
                           input logic d_en, input logic d_wr,
                           input mem_types_pkg::addr_t d_addr,
                           input mem_types_pkg::word_t d_wdata);
        row_t r;
        r.i_en    = i_en;
        r.i_addr  = i_addr;
        r.d_en    = d_en;
        r.d_wr    = d_wr;
        r.d_addr  = d_addr;
        r.d_wdata = d_wdata;
        rows.push_back(r);
    endtask

    task automatic add_random_row();
        logic                 i_en;
        logic                 d_en;
        logic                 d_wr;
        mem_types_pkg::addr_t ia;
        mem_types_pkg::addr_t da;
        mem_types_pkg::word_t wd;
        i_en = ($urandom % 4) != 0;
        d_en = ($urandom % 4) != 0;
        d_wr = $urandom % 2;
        ia   = random_addr();
        da   = random_addr();
        wd   = $urandom;
        // Never an empty row
        add_row(i_en, ia, d_en || !i_en, d_wr, da, wd);
    endtask

    // Advance both mirrors through one row with memory traffic in grant order
    task automatic predict_row(input row_t r, output mem_types_pkg::word_t exp_i,
                               output mem_types_pkg::word_t exp_d,
                               output logic i_hit, output logic d_hit);
        mem_types_pkg::tag_t it;
        mem_types_pkg::tag_t dt;
        logic                i_pend;
        logic                wb_pend;
        logic                fill_pend;
        logic                pick_data;
        it        = tag_of(r.i_addr);
        dt        = tag_of(r.d_addr);
        i_hit     = r.i_en && i_valid && (i_tag == it);
        d_hit     = r.d_en && d_valid && (d_tag == dt);
        i_pend    = r.i_en && !i_hit;
        fill_pend = r.d_en && !d_hit;
        wb_pend   = fill_pend && d_valid && d_dirty;
        while (i_pend || wb_pend || fill_pend) begin
            // On a tie the side not served last wins
            pick_data = (wb_pend || fill_pend) && (!i_pend || !last_data);
            if (!pick_data) begin
                i_line  = ref_mem[index_of(it)];
                i_tag   = it;
                i_valid = 1'b1;
                i_pend  = 1'b0;
            end else if (wb_pend) begin
                // Old line goes back to its own address
                ref_mem[index_of(d_tag)] = d_line;
                d_dirty = 1'b0;
                wb_pend = 1'b0;
            end else begin
                d_line    = ref_mem[index_of(dt)];
                d_tag     = dt;
                d_valid   = 1'b1;
                d_dirty   = 1'b0;
                fill_pend = 1'b0;
            end
            last_data = pick_data;
        end
        if (r.d_en && r.d_wr) begin
            d_line[word_pos(r.d_addr) +: 32] = r.d_wdata;
            d_dirty = 1'b1;
        end
        exp_i = i_line[word_pos(r.i_addr) +: 32];
        exp_d = d_line[word_pos(r.d_addr) +: 32];
    endtask

    task automatic check_word(input string name, input int row,
                              input mem_types_pkg::word_t got,
                              input mem_types_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR row %0d %s: got 0x%08h, expected 0x%08h", row, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input int row, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Row %0d: %s pulsed %0d times where %0d was expected", row, name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input int row, input int got);
        if (got != 1) begin
            errors++;
            $display("Row %0d: %s hit took %0d cycles instead of 1", row, name, got);
        end
    endtask

    task automatic run_row(input int n, input row_t r);
        mem_types_pkg::word_t exp_i;
        mem_types_pkg::word_t exp_d;
        mem_types_pkg::word_t got_i;
        mem_types_pkg::word_t got_d;
        logic                 i_hit;
        logic                 d_hit;
        int                   i_pulses;
        int                   d_pulses;
        int                   i_lat;
        int                   d_lat;
        int                   lat;
        int                   settle;
        predict_row(r, exp_i, exp_d, i_hit, d_hit);
        i_pulses = 0;
        d_pulses = 0;
        lat      = 0;
        settle   = 0;
        @(posedge clk);
        #2;
        instr_addr = r.i_addr;
        instr_read = r.i_en;
        data_addr  = r.d_addr;
        data_read  = r.d_en && !r.d_wr;
        data_write = r.d_en && r.d_wr;
        data_wdata = r.d_wdata;
        // Two more cycles after both pulses catch a repeated response on either side
        while (settle < 3) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            if (instr_resp) begin
                i_pulses++;
                got_i = instr_rdata;
                i_lat = lat;
            end
            if (data_resp) begin
                d_pulses++;
                got_d = data_rdata;
                d_lat = lat;
            end
            if ((!r.i_en || i_pulses > 0) && (!r.d_en || d_pulses > 0)) begin
                settle++;
            end
        end
        @(posedge clk);
        #2;
        instr_read = 1'b0;
        data_read  = 1'b0;
        data_write = 1'b0;
        check_resp("instr_resp", n, i_pulses, r.i_en ? 1 : 0);
        check_resp("data_resp", n, d_pulses, r.d_en ? 1 : 0);
        if (r.i_en && i_pulses == 1) begin
            check_word("instr_rdata", n, got_i, exp_i);
            if (i_hit) begin
                check_latency("instr", n, i_lat);
            end
        end
        if (r.d_en && d_pulses == 1) begin
            if (!r.d_wr) begin
                check_word("data_rdata", n, got_d, exp_d);
            end
            if (d_hit) begin
                check_latency("data", n, d_lat);
            end
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        timeouts++;
        $display("Timeout: the rows did not finish within %0d cycles", cycle_limit);
        finish_run();
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        instr_addr = '0;
        instr_read = 1'b0;
        data_addr  = '0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_wdata = '0;
        void'($urandom(32'h1326c631));
        // Zeroed memory then a hit in the same line
        add_row(1, 32'h000, 0, 0, 32'h000, 32'h0);
        add_row(1, 32'h004, 0, 0, 32'h000, 32'h0);
        // Store and read back while the neighbour word keeps its old value
        add_row(0, 32'h000, 1, 1, 32'h040, 32'hdeadbeef);
        add_row(0, 32'h000, 1, 0, 32'h040, 32'h0);
        add_row(0, 32'h000, 1, 0, 32'h044, 32'h0);
        // Other line evicts the dirty one so the fetch sees the store
        add_row(0, 32'h000, 1, 0, 32'h0a0, 32'h0);
        add_row(1, 32'h040, 0, 0, 32'h000, 32'h0);
        // Both ports miss together several times in a row
        add_row(1, 32'h100, 1, 0, 32'h140, 32'h0);
        add_row(1, 32'h180, 1, 1, 32'h1c0, 32'h0badf00d);
        add_row(1, 32'h1c0, 1, 0, 32'h0a4, 32'h0);
        add_row(1, 32'h1e4, 1, 1, 32'h064, 32'hcafe0001);
        // Alias one memory depth above line 2
        add_row(0, 32'h000, 1, 1, 32'h244, 32'h12345678);
        add_row(0, 32'h000, 1, 0, 32'h000, 32'h0);
        add_row(1, 32'h044, 1, 0, 32'h040, 32'h0);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            add_random_row();
        end
        for (int i = 0; i < PMEM_LINES; i++) begin
            ref_mem[i] = '0;
        end
        i_valid     = 1'b0;
        d_valid     = 1'b0;
        d_dirty     = 1'b0;
        // Instr side wins the first tie
        last_data   = 1'b1;
        cycle_limit = rows.size() * (4 * PMEM_LATENCY + 12) + 4;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[n]) begin
            run_row(n, rows[n]);
        end
        finish_run();
    end

endmodule
